/* hw/core_pkg.sv */
/*
 * Shared field widths and encodings for the stack processor core.
 * Modules pull these in with a wildcard import in their header.
 */

`default_nettype none

package core_pkg;

	// Instruction fields ---------------
	localparam int NBOPCO = 5;
	localparam int NBOPER = 9;
	localparam int NBINST = NBOPCO + NBOPER;

	// Opcodes, anything not listed runs as NOP
	typedef enum logic [NBOPCO-1:0] {
		NOP   = 5'd0,
		LOD   = 5'd1,
		SET   = 5'd2,
		PSH   = 5'd3,
		POP   = 5'd4,
		INN   = 5'd5,
		OUT   = 5'd6,
		ADD   = 5'd7,
		S_ADD = 5'd8,
		AND   = 5'd9,
		LES   = 5'd10,
		JMP   = 5'd15,
		JIZ   = 5'd16,
		CAL   = 5'd17,
		RET   = 5'd18
	} opcode_e;

	// ALU functions ---------------
	// PASS forwards in2 (acc or input), LOAD forwards in1 (memory or stack)
	typedef enum logic [2:0] {
		ALU_PASS = 3'd0,
		ALU_LOAD = 3'd1,
		ALU_ADD  = 3'd2,
		ALU_AND  = 3'd3,
		ALU_LES  = 3'd4
	} alu_op_e;

endpackage

`default_nettype wire

/* hw/lifo_stack.sv */
/*
 * Pointer based LIFO. Serves as the return address stack in the fetch
 * unit and as the data stack in the core. Wraps silently when misused.
 */

`timescale 1ns/1ns
`default_nettype none

module lifo_stack #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 16
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] top
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0]    ptr;
	logic [PW-1:0]    ptr_dec;

	// Pointer always addresses the next free slot
	assign ptr_dec = ptr - 1'b1;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr_dec;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= data_in;
		end
	end

	assign top = mem[ptr_dec];

endmodule

`default_nettype wire

/* hw/alu.sv */
/*
 * Integer ALU, purely combinational. in1 carries memory or stack data,
 * in2 carries the accumulator or the sampled input port.
 */

`timescale 1ns/1ns
`default_nettype none

module alu import core_pkg::*; #(
	parameter int NUBITS = 16
) (
	input  alu_op_e           op,
	input  logic [NUBITS-1:0] in1,
	input  logic [NUBITS-1:0] in2,
	output logic [NUBITS-1:0] result
);

	logic less;

	// LES compares mem against acc as two's complement
	assign less = $signed(in1) < $signed(in2);

	always_comb begin
		case (op)
			ALU_PASS: result = in2;
			ALU_LOAD: result = in1;
			ALU_ADD:  result = in1 + in2;
			ALU_AND:  result = in1 & in2;
			ALU_LES:  result = {{(NUBITS-1){1'b0}}, less};
			default:  result = in2;
		endcase
	end

endmodule

`default_nettype wire

/* hw/instr_fetch.sv */
/*
 * Program counter and next address logic. Jumps, calls and returns are
 * resolved in the decode cycle so the target is fetched with no bubble.
 */

`timescale 1ns/1ns
`default_nettype none

module instr_fetch import core_pkg::*; #(
	parameter int SDEPTH = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [NBINST-1:0] instr,
	input  logic              result_lsb,
	output logic [NBOPER-1:0] instr_addr
);

	opcode_e           opcode;
	logic [NBOPER-1:0] operand;
	logic              is_jmp;
	logic              is_jiz;
	logic              is_cal;
	logic              is_ret;
	logic              load_operand;
	logic [NBOPER-1:0] pc;
	logic [NBOPER-1:0] ret_addr;
	logic [NBOPER-1:0] next_addr;

	assign opcode  = opcode_e'(instr[NBINST-1:NBOPER]);
	assign operand = instr[NBOPER-1:0];

	// Branch decode ---------------
	assign is_jmp = (opcode == JMP);
	assign is_jiz = (opcode == JIZ);
	assign is_cal = (opcode == CAL);
	assign is_ret = (opcode == RET);

	// JIZ looks at the result of the instruction in execute
	assign load_operand = is_jmp | is_cal | (is_jiz & ~result_lsb);

	// Return stack holds the address after each call
	lifo_stack #(
		.DEPTH(SDEPTH),
		.WIDTH(NBOPER)
	) u_ret_stack (
		.clk    (clk),
		.rst    (rst),
		.push   (is_cal),
		.pop    (is_ret),
		.data_in(pc),
		.top    (ret_addr)
	);

	always_comb begin
		if (is_ret) begin
			next_addr = ret_addr;
		end else if (load_operand) begin
			next_addr = operand;
		end else begin
			next_addr = pc;
		end
	end

	// Word 0 is fetched while reset is held
	assign instr_addr = rst ? '0 : next_addr;

	// PC runs one ahead of the address on the bus
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= NBOPER'(1);
		end else begin
			pc <= next_addr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/instr_dec.sv */
/*
 * Instruction decoder. Gives the decode cycle strobes for the stack,
 * memory read and input port, and registers the execute stage controls.
 */

`timescale 1ns/1ns
`default_nettype none

module instr_dec import core_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [NBINST-1:0] instr,
	output logic              dsp_push,
	output logic              dsp_pop,
	output logic              in_req,
	output logic              out_req,
	output alu_op_e           alu_op,
	output logic              in1_from_stack,
	output logic              in2_from_io,
	output logic              mem_wr,
	output logic [NBOPER-1:0] mem_addr_rd,
	output logic [NBOPER-1:0] mem_addr_wr
);

	opcode_e opcode;
	alu_op_e op_d;
	logic    stk_d;
	logic    io_d;
	logic    wr_d;
	logic    out_d;

	assign opcode      = opcode_e'(instr[NBINST-1:NBOPER]);
	assign mem_addr_rd = instr[NBOPER-1:0];

	// Decode cycle ---------------
	always_comb begin
		dsp_push = 1'b0;
		dsp_pop  = 1'b0;
		in_req   = 1'b0;
		op_d     = ALU_PASS;
		stk_d    = 1'b0;
		io_d     = 1'b0;
		wr_d     = 1'b0;
		out_d    = 1'b0;
		case (opcode)
			LOD: op_d = ALU_LOAD;
			SET: wr_d = 1'b1;
			PSH: dsp_push = 1'b1;
			POP: begin
				dsp_pop = 1'b1;
				stk_d   = 1'b1;
				op_d    = ALU_LOAD;
			end
			INN: begin
				in_req = 1'b1;
				io_d   = 1'b1;
			end
			OUT: out_d = 1'b1;
			ADD: op_d = ALU_ADD;
			S_ADD: begin
				dsp_pop = 1'b1;
				stk_d   = 1'b1;
				op_d    = ALU_ADD;
			end
			AND: op_d = ALU_AND;
			LES: op_d = ALU_LES;
			// Branches are handled in fetch, acc just holds
			default: op_d = ALU_PASS;
		endcase
	end

	// Execute stage controls ---------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_op         <= ALU_PASS;
			in1_from_stack <= 1'b0;
			in2_from_io    <= 1'b0;
			mem_wr         <= 1'b0;
			mem_addr_wr    <= '0;
			out_req        <= 1'b0;
		end else begin
			alu_op         <= op_d;
			in1_from_stack <= stk_d;
			in2_from_io    <= io_d;
			mem_wr         <= wr_d;
			mem_addr_wr    <= mem_addr_rd;
			out_req        <= out_d;
		end
	end

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
/*
 * Execute stage. Picks the ALU operands, runs the ALU and keeps the
 * accumulator, which takes the ALU result at the end of every cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module exec_unit import core_pkg::*; #(
	parameter int NUBITS = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  alu_op_e           alu_op,
	input  logic              in1_from_stack,
	input  logic              in2_from_io,
	input  logic [NUBITS-1:0] stack_top,
	input  logic [NUBITS-1:0] mem_data_rd,
	input  logic [NUBITS-1:0] io_in,
	output logic [NUBITS-1:0] result,
	output logic [NUBITS-1:0] acc,
	output logic              result_lsb
);

	logic [NUBITS-1:0] stk_q;
	logic [NUBITS-1:0] io_q;
	logic [NUBITS-1:0] in1;
	logic [NUBITS-1:0] in2;

	// Capture stack top and input port as decode ends
	always_ff @(posedge clk) begin
		stk_q <= stack_top;
		io_q  <= io_in;
	end

	// Operand select ---------------
	assign in1 = in1_from_stack ? stk_q : mem_data_rd;
	assign in2 = in2_from_io ? io_q : acc;

	alu #(
		.NUBITS(NUBITS)
	) u_alu (
		.op    (alu_op),
		.in1   (in1),
		.in2   (in2),
		.result(result)
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= result;
		end
	end

	// Condition bit for JIZ in fetch
	assign result_lsb = result[0];

endmodule

`default_nettype wire

/* hw/io_ctrl.sv */
/*
 * Numbered I/O port control. Input requests go out in the decode cycle,
 * the output port address is carried into the execute cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module io_ctrl import core_pkg::*; #(
	parameter int NBIOIN = 2,
	parameter int NBIOOU = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_req,
	input  logic              out_req,
	input  logic [NBOPER-1:0] operand,
	output logic              req_in,
	output logic [NBIOIN-1:0] addr_in,
	output logic              out_en,
	output logic [NBIOOU-1:0] addr_out
);

	// Input side, same cycle as decode
	assign req_in  = in_req;
	assign addr_in = operand[NBIOIN-1:0];

	// Output side ---------------
	// out_req already sits in execute, line the port address up with it
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			addr_out <= '0;
		end else begin
			addr_out <= operand[NBIOOU-1:0];
		end
	end

	assign out_en = out_req;

endmodule

`default_nettype wire

/* hw/stack_core.sv */
/*
 * Two stage stack processor top level. Connect synchronous instruction and
 * data memories with one cycle read latency and the numbered I/O ports.
 */

`timescale 1ns/1ns
`default_nettype none

module stack_core import core_pkg::*; #(
	parameter int NUBITS = 16,
	parameter int SDEPTH = 8,
	parameter int DDEPTH = 8,
	parameter int NBIOIN = 2,
	parameter int NBIOOU = 2
) (
	input  logic              clk,
	input  logic              rst,
	// Instruction memory
	output logic [NBOPER-1:0] instr_addr,
	input  logic [NBINST-1:0] instr,
	// Data memory
	output logic [NBOPER-1:0] mem_addr_rd,
	input  logic [NUBITS-1:0] mem_data_rd,
	output logic              mem_wr,
	output logic [NBOPER-1:0] mem_addr_wr,
	output logic [NUBITS-1:0] mem_data_wr,
	// I/O ports
	output logic              req_in,
	output logic [NBIOIN-1:0] addr_in,
	input  logic [NUBITS-1:0] io_in,
	output logic              out_en,
	output logic [NBIOOU-1:0] addr_out,
	output logic [NUBITS-1:0] io_out
);

	logic              result_lsb;
	logic              dsp_push;
	logic              dsp_pop;
	logic              in_req;
	logic              out_req;
	alu_op_e           alu_op;
	logic              in1_from_stack;
	logic              in2_from_io;
	logic [NUBITS-1:0] stack_top;
	logic [NUBITS-1:0] result;

	// Fetch and decode ---------------
	instr_fetch #(
		.SDEPTH(SDEPTH)
	) u_fetch (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.result_lsb(result_lsb),
		.instr_addr(instr_addr)
	);

	instr_dec u_dec (
		.clk           (clk),
		.rst           (rst),
		.instr         (instr),
		.dsp_push      (dsp_push),
		.dsp_pop       (dsp_pop),
		.in_req        (in_req),
		.out_req       (out_req),
		.alu_op        (alu_op),
		.in1_from_stack(in1_from_stack),
		.in2_from_io   (in2_from_io),
		.mem_wr        (mem_wr),
		.mem_addr_rd   (mem_addr_rd),
		.mem_addr_wr   (mem_addr_wr)
	);

	// Data path ---------------
	// Push stores what the accumulator takes at the same edge
	lifo_stack #(
		.DEPTH(DDEPTH),
		.WIDTH(NUBITS)
	) u_data_stack (
		.clk    (clk),
		.rst    (rst),
		.push   (dsp_push),
		.pop    (dsp_pop),
		.data_in(result),
		.top    (stack_top)
	);

	exec_unit #(
		.NUBITS(NUBITS)
	) u_exec (
		.clk           (clk),
		.rst           (rst),
		.alu_op        (alu_op),
		.in1_from_stack(in1_from_stack),
		.in2_from_io   (in2_from_io),
		.stack_top     (stack_top),
		.mem_data_rd   (mem_data_rd),
		.io_in         (io_in),
		.result        (result),
		.acc           (io_out),
		.result_lsb    (result_lsb)
	);

	assign mem_data_wr = result;

	io_ctrl #(
		.NBIOIN(NBIOIN),
		.NBIOOU(NBIOOU)
	) u_io (
		.clk     (clk),
		.rst     (rst),
		.in_req  (in_req),
		.out_req (out_req),
		.operand (mem_addr_rd),
		.req_in  (req_in),
		.addr_in (addr_in),
		.out_en  (out_en),
		.addr_out(addr_out)
	);

endmodule

`default_nettype wire

/* tests/tb_programs.svh */
/*
 * Test program and tables for the stack core testbench. Included into the
 * testbench module once NUBITS, NBIOIN and event_row_t are declared.
 */

`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Input port values, indexed by port number
localparam logic [NUBITS-1:0] IN0 = 16'h0007;
localparam logic [NUBITS-1:0] IN1 = 16'h1234;
localparam logic [NUBITS-1:0] IN2 = 16'h0030;
localparam logic [NUBITS-1:0] IN3 = 16'h4000;
localparam logic [NUBITS-1:0] IN_VALUES [1 << NBIOIN] = '{IN0, IN1, IN2, IN3};

// Preloaded data words, D12 and D13 are the signed extremes
localparam logic [NUBITS-1:0] D10 = 16'h0101;
localparam logic [NUBITS-1:0] D11 = 16'h0ff0;
localparam logic [NUBITS-1:0] D12 = 16'h8000;
localparam logic [NUBITS-1:0] D13 = 16'h7fff;
localparam int NDATA = 4;
localparam logic [NBOPER-1:0] DATA_ADDR [NDATA] = '{9'd10, 9'd11, 9'd12, 9'd13};
localparam logic [NUBITS-1:0] DATA_VALUE [NDATA] = '{D10, D11, D12, D13};

// Program, one word per address starting at 0
localparam int NPROG = 29;
localparam logic [NBINST-1:0] PROGRAM [NPROG] = '{
	// Memory, ALU and ports
	{LOD, 9'd10},
	{SET, 9'd20},
	{INN, 9'd1},
	{ADD, 9'd20},   // reads back the word just written
	{OUT, 9'd1},
	{AND, 9'd11},
	{OUT, 9'd2},
	{INN, 9'd2},
	// LES gives 1, JIZ falls through
	{LES, 9'd12},
	{JIZ, 9'd28},
	{OUT, 9'd3},
	// LES gives 0, JIZ skips one OUT
	{LES, 9'd13},
	{JIZ, 9'd14},
	{OUT, 9'd3},
	{OUT, 9'd0},
	// Data stack
	{INN, 9'd3},
	{PSH, 9'd0},
	{LOD, 9'd10},
	{PSH, 9'd0},
	{INN, 9'd0},
	{S_ADD, 9'd0},
	{OUT, 9'd2},
	{POP, 9'd0},
	// Jump over an OUT, then call and return
	{JMP, 9'd25},
	{OUT, 9'd0},
	{OUT, 9'd1},
	{CAL, 9'd29},
	{OUT, 9'd3},
	{JMP, 9'd28}
};

// Subroutine at 29, placed by the testbench after the main program
localparam int SUB_BASE = 29;
localparam int NSUB = 3;
localparam logic [NBINST-1:0] SUBROUTINE [NSUB] = '{
	{ADD, 9'd10},
	{SET, 9'd21},
	{RET, 9'd0}
};

// Expected events in order: write flag, port or address, value
localparam int NEVENTS = 9;
localparam event_row_t EXPECTED_EVENTS [NEVENTS] = '{
	'{1'b1, 9'd20, D10},
	'{1'b0, 9'd1, IN1 + D10},
	'{1'b0, 9'd2, (IN1 + D10) & D11},
	'{1'b0, 9'd3, ($signed(D12) < $signed(IN2)) ? 16'd1 : 16'd0},
	'{1'b0, 9'd0, ($signed(D13) < $signed(16'd1)) ? 16'd1 : 16'd0},
	'{1'b0, 9'd2, D10 + IN0},
	'{1'b0, 9'd1, IN3},
	'{1'b1, 9'd21, IN3 + D10},
	'{1'b0, 9'd3, IN3 + D10}
};

`endif

/* tests/tb_stack_core.sv */
/*
 * Testbench for stack_core. Runs the program of tb_programs.svh against
 * synchronous memory models and checks every output port event and data
 * memory write, in order, against the expected event table.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_stack_core import core_pkg::*; ();

	localparam int NUBITS = 16;
	localparam int NBIOIN = 2;
	localparam int NBIOOU = 2;
	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 4;
	localparam int CYCLES_PER_ROW = 20;
	localparam int TAIL_CYCLES = 40;
	localparam logic [NUBITS-1:0] IDLE_INPUT = 16'hbad0;

	typedef struct packed {
		logic              is_write;
		logic [NBOPER-1:0] addr;
		logic [NUBITS-1:0] data;
	} event_row_t;

	`include "tb_programs.svh"

	localparam int WATCHDOG_NS =
		(RESET_CYCLES + NEVENTS * CYCLES_PER_ROW + TAIL_CYCLES) * CLK_PERIOD;

	logic              clk;
	logic              rst;
	logic [NBOPER-1:0] instr_addr;
	logic [NBINST-1:0] instr = '0;
	logic [NBOPER-1:0] mem_addr_rd;
	logic [NUBITS-1:0] mem_data_rd = '0;
	logic              mem_wr;
	logic [NBOPER-1:0] mem_addr_wr;
	logic [NUBITS-1:0] mem_data_wr;
	logic              req_in;
	logic [NBIOIN-1:0] addr_in;
	logic [NUBITS-1:0] io_in = '0;
	logic              out_en;
	logic [NBIOOU-1:0] addr_out;
	logic [NUBITS-1:0] io_out;

	logic [NBINST-1:0] rom [1 << NBOPER];
	logic [NUBITS-1:0] ram [1 << NBOPER];

	stack_core #(
		.NUBITS(NUBITS),
		.SDEPTH(8),
		.DDEPTH(8),
		.NBIOIN(NBIOIN),
		.NBIOOU(NBIOOU)
	) dut (
		.clk        (clk),
		.rst        (rst),
		.instr_addr (instr_addr),
		.instr      (instr),
		.mem_addr_rd(mem_addr_rd),
		.mem_data_rd(mem_data_rd),
		.mem_wr     (mem_wr),
		.mem_addr_wr(mem_addr_wr),
		.mem_data_wr(mem_data_wr),
		.req_in     (req_in),
		.addr_in    (addr_in),
		.io_in      (io_in),
		.out_en     (out_en),
		.addr_out   (addr_out),
		.io_out     (io_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Memory models ---------------
	// Unused ROM words trap in a jump to themselves
	initial begin
		for (int a = 0; a < (1 << NBOPER); a++) begin
			rom[a] = {JMP, NBOPER'(a)};
			ram[a] <= NUBITS'(a * 37) ^ 16'ha5c3;
		end
		for (int i = 0; i < NPROG; i++) begin
			rom[i] = PROGRAM[i];
		end
		for (int i = 0; i < NSUB; i++) begin
			rom[SUB_BASE + i] = SUBROUTINE[i];
		end
		for (int i = 0; i < NDATA; i++) begin
			ram[DATA_ADDR[i]] <= DATA_VALUE[i];
		end
	end

	always @(posedge clk) begin
		instr       <= rom[instr_addr];
		mem_data_rd <= ram[mem_addr_rd];
		if (mem_wr) begin
			ram[mem_addr_wr] <= mem_data_wr;
		end
	end

	// Input source answers within the request cycle
	always @(negedge clk) begin
		if (req_in) begin
			io_in <= IN_VALUES[addr_in];
		end else begin
			io_in <= IDLE_INPUT;
		end
	end

	// Checking ---------------
	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [NUBITS-1:0] got,
			input logic [NUBITS-1:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [NBOPER-1:0] got,
			input logic [NBOPER-1:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_strobes_idle();
		check_bit("out_en", out_en, 1'b0);
		check_bit("mem_wr", mem_wr, 1'b0);
		check_bit("req_in", req_in, 1'b0);
	endtask

	// Each event lasts one cycle, so step past the previous one first
	task automatic wait_for_event();
		@(negedge clk);
		while (!(out_en || mem_wr)) begin
			@(negedge clk);
		end
	endtask

	task automatic check_event(input int index);
		event_row_t row;
		row = EXPECTED_EVENTS[index];
		if (row.is_write) begin
			if (!mem_wr) begin
				$display("event %0d should be a memory write, an output came first", index);
				stop_run();
			end
			check_addr("mem_addr_wr", mem_addr_wr, row.addr);
			check_word("mem_data_wr", mem_data_wr, row.data);
		end else begin
			if (!out_en) begin
				$display("event %0d should be an output, a memory write came first", index);
				stop_run();
			end
			check_addr("addr_out", NBOPER'(addr_out), row.addr);
			check_word("io_out", io_out, row.data);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, expected events are still missing", WATCHDOG_NS);
		stop_run();
	end

	initial begin
		rst = 1'b1;
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(negedge clk);
			check_addr("instr_addr", instr_addr, '0);
			check_strobes_idle();
		end
		rst = 1'b0;
		@(negedge clk);
		check_strobes_idle();

		for (int r = 0; r < NEVENTS; r++) begin
			wait_for_event();
			check_event(r);
		end

		// Program now spins in its final jump
		repeat (TAIL_CYCLES) begin
			@(negedge clk);
			if (out_en || mem_wr) begin
				$display("unexpected output or memory write at %0t ns after the last event", $time);
				stop_run();
			end
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+tests
hw/core_pkg.sv
hw/lifo_stack.sv
hw/alu.sv
hw/instr_fetch.sv
hw/instr_dec.sv
hw/exec_unit.sv
hw/io_ctrl.sv
hw/stack_core.sv
tests/tb_stack_core.sv

/* Makefile */
# Verilator build and run for the stack processor testbench

VERILATOR ?= verilator
TOP       ?= tb_stack_core
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) tests/tb_programs.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
